// ==== sources.f ====
verilog/vote_pkg.sv
verilog/vote_selector.sv
verilog/vote_command_decoder.sv
verilog/vote_counter.sv
verilog/vote_result.sv
verilog/vote_accumulator_top.sv
testbench/tb_vote_accumulator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the vote accumulator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_vote_accumulator \
    -f sources.f \
    -o sim_vote

./obj_dir/sim_vote > "$log" 2>&1
cat "$log"

if grep -q "^Everything OK$" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log"
    exit 1
fi

// ==== testbench/tb_vote_accumulator.sv ====
`timescale 1ns/100ps

module tb_vote_accumulator;

    import vote_pkg::*;

    localparam int W = vote_pkg::count_w;
    localparam int CORENUM = vote_pkg::core_num;

    // test sizes
    localparam int n_ones = 20;
    localparam int n_rounds = 4;
    localparam int n_rand = 40;
    localparam int n_pairs = 10;
    localparam int n_low = 8;
    // commands and idle cycles over the whole run
    localparam int total_cmds = 8 + (n_ones + 10) + n_rounds * (n_rand + 2) + 8
        + (2 * n_pairs + 10) + (n_low + 10) + 21 + 15;

    logic                clk;
    logic                rst;
    logic                cmd_valid;
    vote_op_t            cmd_op;
    logic [CORENUM-1:0]  store;
    logic [CORENUM-1:0]  core_result;
    logic                cmd_error;
    logic                result_valid;
    logic signed [W-1:0] result_count;
    logic                result_sign;
    logic                result_tie;

    int unsigned cyc;
    int          seed;
    int          value_errors;
    int          other_errors;
    string       cur_test;
    logic [CORENUM-1:0] rnd_mask;
    logic [CORENUM-1:0] rnd_res;

    // model of the round and the running count
    round_state_t        model_state;
    logic signed [W-1:0] model_count;
    // predicted cmd_error delayed by one cycle
    logic                err_drive;
    logic                err_pred;

    // pending results in finish order
    logic signed [W-1:0] exp_count_q[$];
    logic                exp_sign_q[$];
    logic                exp_tie_q[$];
    int unsigned         exp_cyc_q[$];
    string               exp_name_q[$];
    // last result seen and still held by the DUT
    logic signed [W-1:0] last_count;
    logic                last_sign;
    logic                last_tie;

    vote_accumulator_top #(
        .W       (W),
        .CORENUM (CORENUM)
    ) vote_accumulator_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .store        (store),
        .core_result  (core_result),
        .cmd_error    (cmd_error),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_sign  (result_sign),
        .result_tie   (result_tie)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle number and error prediction pipeline
    always @(posedge clk) begin
        if (rst) begin
            cyc      <= 0;
            err_pred <= 1'b0;
        end else begin
            cyc      <= cyc + 1;
            err_pred <= err_drive;
        end
    end

    // sum of +1 / -1 / 0 over all cores
    function automatic int step_votes(input logic [CORENUM-1:0] msk,
                                      input logic [CORENUM-1:0] res);
        int sum;
        sum = 0;
        for (int i = 0; i < CORENUM; i++) begin
            if (msk[i]) begin
                if (res[i]) begin
                    sum = sum + 1;
                end else begin
                    sum = sum - 1;
                end
            end
        end
        return sum;
    endfunction

    task automatic check_result(input string test_name, input vote_op_t op,
                                input logic signed [W-1:0] exp_count,
                                input logic signed [W-1:0] act_count,
                                input logic exp_sign, input logic act_sign,
                                input logic exp_tie, input logic act_tie);
        if (act_count !== exp_count) begin
            $display("ERR %s %s count expected %0d actual %0d",
                     test_name, op.name(), exp_count, act_count);
            value_errors++;
        end
        if (act_sign !== exp_sign) begin
            $display("ERR %s %s sign expected %b actual %b",
                     test_name, op.name(), exp_sign, act_sign);
            value_errors++;
        end
        if (act_tie !== exp_tie) begin
            $display("ERR %s %s tie expected %b actual %b",
                     test_name, op.name(), exp_tie, act_tie);
            value_errors++;
        end
    endtask

    task automatic check_error(input string test_name, input logic exp_err,
                               input logic act_err);
        if (act_err !== exp_err) begin
            $display("ERR %s cmd_error expected %b actual %b", test_name, exp_err, act_err);
            value_errors++;
        end
    endtask

    // drive one command and advance the model
    task automatic issue(input vote_op_t op, input logic [CORENUM-1:0] msk,
                         input logic [CORENUM-1:0] res);
        logic err;
        err = 1'b0;
        @(posedge clk);
        #1;
        cmd_valid   = 1'b1;
        cmd_op      = op;
        store       = msk;
        core_result = res;
        case (op)
            op_start: begin
                model_state = st_open;
                model_count = '0;
            end
            op_vote: begin
                if (model_state == st_open) begin
                    model_count = model_count + W'(step_votes(msk, res));
                end else begin
                    err = 1'b1;
                end
            end
            op_finish: begin
                if (model_state == st_open) begin
                    // negative count means a majority of zeros
                    exp_count_q.push_back(model_count);
                    exp_sign_q.push_back(model_count < 0);
                    exp_tie_q.push_back(model_count == 0);
                    exp_cyc_q.push_back(cyc + 4);
                    exp_name_q.push_back(cur_test);
                    model_state = st_idle;
                end else begin
                    err = 1'b1;
                end
            end
            default: begin
                err = 1'b0;
            end
        endcase
        err_drive = err;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            cmd_valid = 1'b0;
            cmd_op    = op_nop;
            err_drive = 1'b0;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_error(cur_test, err_pred, cmd_error);
            if (result_valid) begin
                if (exp_count_q.size() == 0) begin
                    $display("result_valid at cycle %0d with no finished round pending", cyc);
                    other_errors++;
                end else begin
                    if (exp_cyc_q[0] != cyc) begin
                        $display("ERR %s latency expected cycle %0d actual cycle %0d",
                                 exp_name_q[0], exp_cyc_q[0], cyc);
                        value_errors++;
                    end
                    last_count = exp_count_q.pop_front();
                    last_sign  = exp_sign_q.pop_front();
                    last_tie   = exp_tie_q.pop_front();
                    void'(exp_cyc_q.pop_front());
                    check_result(exp_name_q.pop_front(), op_finish, last_count, result_count,
                                 last_sign, result_sign, last_tie, result_tie);
                end
            end
        end
    end

    // run limit from the number of commands
    initial begin
        #(total_cmds * 4 + 200 * 4);
        $display("watchdog timeout, the run did not reach its end in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = op_nop;
        store        = '0;
        core_result  = '0;
        seed         = 32'hf8a84b48;
        value_errors = 0;
        other_errors = 0;
        cur_test     = "reset";
        model_state  = st_idle;
        model_count  = '0;
        err_drive    = 1'b0;
        last_count   = '0;
        last_sign    = 1'b0;
        last_tie     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // nothing may come out before a command
        idle(8);

        // every core votes up
        cur_test = "all_ones";
        issue(op_start, '0, '0);
        repeat (n_ones) issue(op_vote, '1, '1);
        issue(op_finish, '0, '0);
        idle(8);

        // back-to-back random steps and rounds
        cur_test = "random_pipeline";
        for (int r = 0; r < n_rounds; r++) begin
            issue(op_start, '0, '0);
            for (int v = 0; v < n_rand; v++) begin
                rnd_mask = CORENUM'($random(seed));
                rnd_res  = CORENUM'($random(seed));
                issue(op_vote, rnd_mask, rnd_res);
            end
            issue(op_finish, '0, '0);
        end
        idle(8);

        // each step followed by its mirror image
        cur_test = "balanced_tie";
        issue(op_start, '0, '0);
        for (int p = 0; p < n_pairs; p++) begin
            rnd_mask = CORENUM'($random(seed));
            rnd_res  = CORENUM'($random(seed));
            issue(op_vote, rnd_mask, rnd_res);
            issue(op_vote, rnd_mask, ~rnd_res);
        end
        issue(op_finish, '0, '0);
        idle(8);

        // results mostly zero
        cur_test = "majority_zero";
        issue(op_start, '0, '0);
        for (int v = 0; v < n_low; v++) begin
            rnd_res = CORENUM'($random(seed) & $random(seed) & $random(seed));
            issue(op_vote, '1, rnd_res);
        end
        issue(op_finish, '0, '0);
        idle(8);

        // last vote lands right before the restart
        cur_test = "restart";
        issue(op_start, '0, '0);
        repeat (5) issue(op_vote, '1, '1);
        issue(op_nop, '0, '0);
        issue(op_vote, '1, '0);
        issue(op_start, '0, '0);
        for (int v = 0; v < 3; v++) begin
            rnd_mask = CORENUM'($random(seed));
            rnd_res  = CORENUM'($random(seed));
            issue(op_vote, rnd_mask, rnd_res);
        end
        issue(op_finish, '0, '0);
        idle(8);

        // commands outside a round
        cur_test = "idle_errors";
        issue(op_vote, '1, '1);
        issue(op_finish, '0, '0);
        issue(op_nop, '0, '0);
        issue(op_vote, '1, '0);
        idle(8);
        check_result(cur_test, op_finish, last_count, result_count,
                     last_sign, result_sign, last_tie, result_tie);
        idle(3);

        if (exp_count_q.size() != 0) begin
            $display("%0d finished rounds never produced a result", exp_count_q.size());
            other_errors++;
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/vote_accumulator_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_accumulator_top #(
    // accumulator width
    parameter int W = vote_pkg::count_w,
    // number of voting cores
    parameter int CORENUM = vote_pkg::core_num
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  vote_pkg::vote_op_t  cmd_op,
    input  logic [CORENUM-1:0]  store,
    input  logic [CORENUM-1:0]  core_result,
    output logic                cmd_error,
    output logic                result_valid,
    output logic signed [W-1:0] result_count,
    output logic                result_sign,
    output logic                result_tie
);

    // decoder to counter
    logic clear_pulse;
    logic vote_pulse;
    logic finish_pulse;

    // counter to result stage
    logic signed [W-1:0] count;
    logic                drain_pulse;

    vote_command_decoder vote_command_decoder_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .clear_pulse  (clear_pulse),
        .vote_pulse   (vote_pulse),
        .finish_pulse (finish_pulse),
        .cmd_error    (cmd_error)
    );

    // store and core_result go straight to the selectors
    vote_counter #(
        .W       (W),
        .CORENUM (CORENUM)
    ) vote_counter_inst (
        .clk          (clk),
        .rst          (rst),
        .store        (store),
        .core_result  (core_result),
        .clear_pulse  (clear_pulse),
        .vote_pulse   (vote_pulse),
        .finish_pulse (finish_pulse),
        .count        (count),
        .drain_pulse  (drain_pulse)
    );

    vote_result #(
        .W (W)
    ) vote_result_inst (
        .clk          (clk),
        .rst          (rst),
        .count        (count),
        .drain_pulse  (drain_pulse),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_sign  (result_sign),
        .result_tie   (result_tie)
    );

endmodule

`default_nettype wire

// ==== verilog/vote_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_result #(
    // accumulator width
    parameter int W = 30
) (
    input  logic                clk,
    input  logic                rst,
    input  logic signed [W-1:0] count,
    input  logic                drain_pulse,
    output logic                result_valid,
    output logic signed [W-1:0] result_count,
    output logic                result_sign,
    output logic                result_tie
);

    // count is final once drain arrives
    logic count_zero;

    assign count_zero = (count == '0);

    // one-cycle strobe per finished round
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= drain_pulse;
        end
    end

    // captured values stay until the next drain
    always_ff @(posedge clk) begin
        if (drain_pulse) begin
            result_count <= count;
            // top bit set means more down votes
            result_sign  <= count[W-1];
            // balanced round
            result_tie   <= count_zero;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vote_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_counter #(
    // accumulator width
    parameter int W = 30,
    // number of voting cores
    parameter int CORENUM = 13
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [CORENUM-1:0]  store,
    input  logic [CORENUM-1:0]  core_result,
    input  logic                clear_pulse,
    input  logic                vote_pulse,
    input  logic                finish_pulse,
    output logic signed [W-1:0] count,
    output logic                drain_pulse
);

    import vote_pkg::*;

    // step tally must hold +-CORENUM
    localparam int tw = tally_bits(CORENUM);

    // one registered vote per core
    vote_t sel [CORENUM];

    // combinational sum of this step's votes
    logic signed [tw-1:0] step_sum;

    // registered step tally, lines up with the delayed pulses
    logic signed [tw-1:0] tally;

    // decoder pulses one stage later
    logic clear_d;
    logic vote_d;
    logic finish_d;

    // selectors sample on the same edge as the decoder
    for (genvar k = 0; k < CORENUM; k++) begin : g_sel
        vote_selector vote_selector_inst (
            .clk             (clk),
            .store_bit       (store[k]),
            .core_result_bit (core_result[k]),
            .sel_bit         (sel[k])
        );
    end

    // add up the votes of all cores
    // signed operands so each vote sign-extends
    always_comb begin
        step_sum = '0;
        for (int i = 0; i < CORENUM; i++) begin
            step_sum = step_sum + sel[i];
        end
    end

    // step tally register
    always_ff @(posedge clk) begin
        tally <= step_sum;
    end

    // delay line for the control pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_d  <= 1'b0;
            vote_d   <= 1'b0;
            finish_d <= 1'b0;
        end else begin
            clear_d  <= clear_pulse;
            vote_d   <= vote_pulse;
            finish_d <= finish_pulse;
        end
    end

    // running count wraps on overflow
    // a clear lands before any vote issued after the start
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear_d) begin
            count <= '0;
        end else if (vote_d) begin
            count <= count + tally;
        end
    end

    // drain follows the count update of every earlier vote
    always_ff @(posedge clk) begin
        if (rst) begin
            drain_pulse <= 1'b0;
        end else begin
            drain_pulse <= finish_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vote_command_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_command_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  vote_pkg::vote_op_t cmd_op,
    output logic               clear_pulse,
    output logic               vote_pulse,
    output logic               finish_pulse,
    output logic               cmd_error
);

    import vote_pkg::*;

    round_state_t state;

    // next-cycle values of the registered pulses
    round_state_t state_next;
    logic         clear_next;
    logic         vote_next;
    logic         finish_next;
    logic         error_next;

    always_comb begin
        state_next  = state;
        clear_next  = 1'b0;
        vote_next   = 1'b0;
        finish_next = 1'b0;
        error_next  = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                op_start: begin
                    // open a round, or restart one already open
                    clear_next = 1'b1;
                    state_next = st_open;
                end
                op_vote: begin
                    if (state == st_open) begin
                        vote_next = 1'b1;
                    end else begin
                        // vote outside a round
                        error_next = 1'b1;
                    end
                end
                op_finish: begin
                    if (state == st_open) begin
                        finish_next = 1'b1;
                        state_next  = st_idle;
                    end else begin
                        // nothing to finish
                        error_next = 1'b1;
                    end
                end
                default: begin
                    // op_nop, no effect
                    state_next = state;
                end
            endcase
        end
    end

    // pulses show up one cycle after the command
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            clear_pulse  <= 1'b0;
            vote_pulse   <= 1'b0;
            finish_pulse <= 1'b0;
            cmd_error    <= 1'b0;
        end else begin
            state        <= state_next;
            clear_pulse  <= clear_next;
            vote_pulse   <= vote_next;
            finish_pulse <= finish_next;
            cmd_error    <= error_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vote_selector.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_selector (
    input  logic           clk,
    input  logic           store_bit,
    input  logic           core_result_bit,
    output vote_pkg::vote_t sel_bit
);

    import vote_pkg::*;

    // store_bit gates the core out of the step
    // result 1 votes up, result 0 votes down
    always_ff @(posedge clk) begin
        if (store_bit) begin
            if (core_result_bit) begin
                sel_bit <= vote_pos;
            end else begin
                sel_bit <= vote_neg;
            end
        end else begin
            // masked core adds nothing
            sel_bit <= vote_zero;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vote_pkg.sv ====
package vote_pkg;

    // command opcodes, only looked at while cmd_valid is high
    typedef enum logic [1:0] {
        op_start  = 2'b00,
        op_vote   = 2'b01,
        op_finish = 2'b10,
        op_nop    = 2'b11
    } vote_op_t;

    // round state of the command decoder
    typedef enum logic {
        st_idle = 1'b0,
        st_open = 1'b1
    } round_state_t;

    // one core's vote, -1, 0 or +1
    typedef logic signed [1:0] vote_t;

    // vote encodings used by the selectors
    localparam vote_t vote_pos  = 2'sb01;
    localparam vote_t vote_neg  = 2'sb11;
    localparam vote_t vote_zero = 2'sb00;

    // default accumulator width
    // largest scanned region needs fewer than 30 bits of count
    localparam int count_w = 30;

    // default core count
    localparam int core_num = 13;

    // bits for a signed step tally of +-cores
    // magnitude bits plus one sign bit
    function automatic int tally_bits(input int cores);
        int mag_bits;
        mag_bits = $clog2(cores + 1);
        return mag_bits + 1;
    endfunction

endpackage
